// File: Makefile
# Verilator build and run of the issue slice testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := issue_pipeline_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TEST PASS

SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+source
source/pipe_pkg.sv
source/pipe_stage.sv
source/data_hazard.sv
source/forward_select.sv
source/issue_control.sv
source/issue_pipeline.sv
verification/issue_pipeline_tb.sv

// File: source/data_hazard.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

// Load-use and MFC0-use stall detection for the ID instruction
// Three flags, one per later stage, evaluated side by side
module data_hazard (
    input  pipe_pkg::dec_instr_t   id_entry,
    input  pipe_pkg::stage_entry_t exe_entry,
    input  pipe_pkg::stage_entry_t mem1_entry,
    input  pipe_pkg::stage_entry_t mem2_entry,
    output logic                   id_exe_stall,
    output logic                   id_mem1_stall,
    output logic                   id_mem2_stall
);

    // ID reads a register that dest will write
    // Register 0 compared like any other
    function automatic logic reads_dest(
        input pipe_pkg::dec_instr_t   id,
        input logic [`REG_ADDR_W-1:0] dest
    );
        logic rs_hit;
        logic rt_hit;
        rs_hit = id.rsrt_read[1] && (id.rs == dest);
        rt_hit = id.rsrt_read[0] && (id.rt == dest);
        return id.valid && (rs_hit || rt_hit);
    endfunction

    // MFC0 recognised from the opcode field alone
    function automatic logic is_mfc0(input logic [`INSTR_W-1:0] instr);
        return instr[`INSTR_W-1:`MFC0_LSB] == `MFC0_FIELD;
    endfunction

    // EXE producer, load or MFC0
    always_comb begin : exe_stall_blk
        id_exe_stall = 1'b0;
        if (reads_dest(id_entry, exe_entry.dest)) begin
            if (exe_entry.valid && (exe_entry.is_load || is_mfc0(exe_entry.instr))) begin
                id_exe_stall = 1'b1;
            end
        end
    end

    // MEM1 producer, load or MFC0
    // Neither result exists yet at the forwarding point
    always_comb begin : mem1_stall_blk
        id_mem1_stall = 1'b0;
        if (reads_dest(id_entry, mem1_entry.dest)) begin
            if (mem1_entry.valid && (mem1_entry.is_load || is_mfc0(mem1_entry.instr))) begin
                id_mem1_stall = 1'b1;
            end
        end
    end

    // MEM2 producer, loads only
    // MFC0 value is ready by MEM2 and gets forwarded instead
    always_comb begin : mem2_stall_blk
        id_mem2_stall = 1'b0;
        if (mem2_entry.valid && mem2_entry.is_load) begin
            if (reads_dest(id_entry, mem2_entry.dest)) begin
                id_mem2_stall = 1'b1;
            end
        end
    end

endmodule

// File: source/forward_select.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

// Operand source selection for the instruction leaving ID
// Youngest producer wins so EXE is checked first
module forward_select (
    input  pipe_pkg::dec_instr_t   id_entry,
    input  pipe_pkg::stage_entry_t exe_entry,
    input  pipe_pkg::stage_entry_t mem1_entry,
    input  pipe_pkg::stage_entry_t mem2_entry,
    output pipe_pkg::fwd_pair_t    fwd
);

    // Stage entry that will write register src
    // Only live entries carry writes_reg
    function automatic logic writes_src(
        input pipe_pkg::stage_entry_t e,
        input logic [`REG_ADDR_W-1:0] src
    );
        return e.writes_reg && (e.dest == src);
    endfunction

    // Priority pick over EXE, MEM1, MEM2
    // Unread source always goes to the register file
    function automatic pipe_pkg::fwd_sel_t pick_source(
        input logic                   read_en,
        input logic [`REG_ADDR_W-1:0] src
    );
        pipe_pkg::fwd_sel_t sel;
        sel = pipe_pkg::FWD_NONE;
        if (read_en) begin
            if (writes_src(exe_entry, src)) begin
                sel = pipe_pkg::FWD_EXE;
            end else if (writes_src(mem1_entry, src)) begin
                sel = pipe_pkg::FWD_MEM1;
            end else if (writes_src(mem2_entry, src)) begin
                sel = pipe_pkg::FWD_MEM2;
            end
        end
        return sel;
    endfunction

    // Select points only at a stage holding a live instruction
    function automatic logic sel_live(input pipe_pkg::fwd_sel_t sel);
        case (sel)
            pipe_pkg::FWD_EXE:  return exe_entry.valid;
            pipe_pkg::FWD_MEM1: return mem1_entry.valid;
            pipe_pkg::FWD_MEM2: return mem2_entry.valid;
            default:            return 1'b1;
        endcase
    endfunction

    always_comb begin
        // rs on mask bit 1, rt on mask bit 0
        fwd.rs_sel = pick_source(id_entry.valid && id_entry.rsrt_read[1], id_entry.rs);
        fwd.rt_sel = pick_source(id_entry.valid && id_entry.rsrt_read[0], id_entry.rt);
    end

    // Stage bubbles must never be a source
    always_comb begin
        rs_sel_live: assert final (sel_live(fwd.rs_sel))
            else $error("forward_select rs names an empty stage");
        rt_sel_live: assert final (sel_live(fwd.rt_sel))
            else $error("forward_select rt names an empty stage");
    end

endmodule

// File: source/hazard_config.svh
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// Register file address width, 32 GPRs
`define REG_ADDR_W 5

// Instruction word width
`define INSTR_W 32

// MFC0 pattern in instr[31:21]
// COP0 major opcode followed by the MF sub-op
`define MFC0_FIELD 11'b010000_00000

// Low bit of the MFC0 field
`define MFC0_LSB 21

`endif

// File: source/issue_control.sv
`timescale 1ns/1ns

// ID register and issue decision
// Holds the decoder while stalled and feeds EXE with bubbles
module issue_control (
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::dec_instr_t   dec_in,
    input  logic                   stall_any,
    output pipe_pkg::dec_instr_t   id_entry,
    output logic                   dec_hold,
    output logic                   issue,
    output pipe_pkg::stage_entry_t exe_next
);

    logic id_load;

    // Issue when ID holds something and no stage blocks it
    assign issue = id_entry.valid && !stall_any;

    // Decoder keeps its output while ID is stuck
    assign dec_hold = id_entry.valid && !issue;

    // ID takes a new word when empty or emptying this cycle
    assign id_load = !id_entry.valid || issue;

    // ID register
    // Gaps from the decoder land as zero entries
    pipe_stage #(
        .payload_t (pipe_pkg::dec_instr_t)
    ) id_stage (
        .clk    (clk),
        .reset  (reset),
        .enable (id_load),
        .bubble (!dec_in.valid),
        .d      (dec_in),
        .q      (id_entry)
    );

    // Entry for EXE on the next edge
    always_comb begin
        exe_next = '0;
        if (issue) begin
            exe_next.valid   = 1'b1;
            exe_next.dest    = id_entry.dest;
            exe_next.is_load = id_entry.is_load;
            // Decoded form has no write enable
            // every issued instruction writes dest
            exe_next.writes_reg = 1'b1;
            exe_next.instr      = id_entry.instr;
        end
    end

    // A held instruction stays put in ID
    // ties the decoder hold to the stall seen across the hazard unit
    id_held_stable: assert property (
        @(posedge clk) disable iff (reset)
        dec_hold |=> $stable(id_entry)
    ) else begin
        $error("issue_control ID entry changed while decoder was held");
    end

endmodule

// File: source/issue_pipeline.sv
`timescale 1ns/1ns

// Issue slice top
// ID, hazard check, forwarding and the EXE, MEM1, MEM2 registers
module issue_pipeline (
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::dec_instr_t   dec_in,
    output logic                   dec_hold,
    output logic                   issue,
    output pipe_pkg::fwd_pair_t    issue_fwd,
    // [2] EXE, [1] MEM1, [0] MEM2
    output logic [2:0]             stall_flags,
    output pipe_pkg::stage_entry_t wb_out
);

    pipe_pkg::dec_instr_t   id_entry;
    pipe_pkg::stage_entry_t exe_next;
    pipe_pkg::stage_entry_t exe_entry;
    pipe_pkg::stage_entry_t mem1_entry;

    // ID register and issue logic
    // Any single stall source holds ID
    issue_control i_issue_control (
        .clk       (clk),
        .reset     (reset),
        .dec_in    (dec_in),
        .stall_any (|stall_flags),
        .id_entry  (id_entry),
        .dec_hold  (dec_hold),
        .issue     (issue),
        .exe_next  (exe_next)
    );

    // Load and MFC0 use checks
    data_hazard i_data_hazard (
        .id_entry      (id_entry),
        .exe_entry     (exe_entry),
        .mem1_entry    (mem1_entry),
        .mem2_entry    (wb_out),
        .id_exe_stall  (stall_flags[2]),
        .id_mem1_stall (stall_flags[1]),
        .id_mem2_stall (stall_flags[0])
    );

    // Operand sources, only meaningful on issue
    forward_select i_forward_select (
        .id_entry   (id_entry),
        .exe_entry  (exe_entry),
        .mem1_entry (mem1_entry),
        .mem2_entry (wb_out),
        .fwd        (issue_fwd)
    );

    // Later stages never stall
    // exe_next already carries the bubble on non-issue cycles
    pipe_stage exe_stage (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .bubble (1'b0),
        .d      (exe_next),
        .q      (exe_entry)
    );

    pipe_stage mem1_stage (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .bubble (1'b0),
        .d      (exe_entry),
        .q      (mem1_entry)
    );

    // MEM2 contents go straight out as the writeback record
    pipe_stage mem2_stage (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .bubble (1'b0),
        .d      (mem1_entry),
        .q      (wb_out)
    );

endmodule

// File: source/pipe_pkg.sv
`include "hazard_config.svh"

package pipe_pkg;

    // Decoded instruction as offered by the decoder and held in ID
    typedef struct packed {
        logic                    valid;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        // Bit 1 reads rs, bit 0 reads rt
        logic [1:0]              rsrt_read;
        logic [`REG_ADDR_W-1:0]  dest;
        logic                    is_load;
        logic [`INSTR_W-1:0]     instr;
    } dec_instr_t;

    // Entry of EXE, MEM1 and MEM2
    // All zeros is a bubble
    typedef struct packed {
        logic                    valid;
        logic [`REG_ADDR_W-1:0]  dest;
        logic                    is_load;
        // Set for anything that writes dest, loads and MFC0 included
        logic                    writes_reg;
        logic [`INSTR_W-1:0]     instr;
    } stage_entry_t;

    // Operand source for one register read
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // Register file
        FWD_EXE  = 2'd1,
        FWD_MEM1 = 2'd2,
        FWD_MEM2 = 2'd3
    } fwd_sel_t;

    // Selects for both sources of the issuing instruction
    typedef struct packed {
        fwd_sel_t rs_sel;
        fwd_sel_t rt_sel;
    } fwd_pair_t;

endpackage

// File: source/pipe_stage.sv
`timescale 1ns/1ns

// Single pipeline register
// Payload type picked per instance, ID uses the decoded form,
// EXE and both MEM stages use the stage entry
module pipe_stage #(
    parameter type payload_t = pipe_pkg::stage_entry_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // Reset and bubble both give the all-zero entry
    // Enable low keeps the current contents
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (enable) begin
            if (bubble) begin
                // Zero entry, valid clear
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

    // No X may leave a stage once reset has cleared it
    // Catches undriven payload bits coming in on d
    q_known_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(q)
    ) else begin
        $error("pipe_stage q carries unknown bits");
    end

endmodule

// File: verification/issue_pipeline_tb.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

module issue_pipeline_tb;

    localparam int MAIN_CYCLES = 2000;
    localparam int IDLE_CYCLES = 4;
    localparam int DRAIN_LIMIT = 50;

    logic                   clk;
    logic                   reset;
    pipe_pkg::dec_instr_t   dec_in;
    logic                   dec_hold;
    logic                   issue;
    pipe_pkg::fwd_pair_t    issue_fwd;
    logic [2:0]             stall_flags;
    pipe_pkg::stage_entry_t wb_out;

    // Reference ID slot and EXE, MEM1, MEM2 shift model
    pipe_pkg::dec_instr_t   m_id;
    pipe_pkg::stage_entry_t m_exe;
    pipe_pkg::stage_entry_t m_mem1;
    pipe_pkg::stage_entry_t m_mem2;

    integer seed;
    int     offered;
    int     retired;
    int     wait_cycles;
    bit     drained;
    int     total_errors;

    // Per-check error counters
    int err_idle;
    int err_stall;
    int err_issue;
    int err_hold;
    int err_fwd;
    int err_wb;
    int err_count;
    int err_timeout;

    issue_pipeline i_issue_pipeline (
        .clk         (clk),
        .reset       (reset),
        .dec_in      (dec_in),
        .dec_hold    (dec_hold),
        .issue       (issue),
        .issue_fwd   (issue_fwd),
        .stall_flags (stall_flags),
        .wb_out      (wb_out)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // MFC0 recognised by bits 31 to 21
    function automatic logic mfc0_word(input logic [`INSTR_W-1:0] instr);
        return instr[`INSTR_W-1:`MFC0_LSB] == `MFC0_FIELD;
    endfunction

    // Valid ID instruction reads a register the entry's dest names
    function automatic logic id_reads(
        input pipe_pkg::dec_instr_t   id,
        input pipe_pkg::stage_entry_t e
    );
        logic rs_use;
        logic rt_use;
        rs_use = id.rsrt_read[1] && (id.rs == e.dest);
        rt_use = id.rsrt_read[0] && (id.rt == e.dest);
        return id.valid && (rs_use || rt_use);
    endfunction

    // Expected flags with [2] EXE, [1] MEM1, [0] MEM2
    function automatic logic [2:0] model_stalls();
        logic [2:0] s;
        s[2] = id_reads(m_id, m_exe) && m_exe.valid
            && (m_exe.is_load || mfc0_word(m_exe.instr));
        s[1] = id_reads(m_id, m_mem1) && m_mem1.valid
            && (m_mem1.is_load || mfc0_word(m_mem1.instr));
        // MEM2 only for loads
        s[0] = id_reads(m_id, m_mem2) && m_mem2.valid && m_mem2.is_load;
        return s;
    endfunction

    // Youngest producer of src or the register file
    function automatic pipe_pkg::fwd_sel_t model_source(
        input logic                   read_en,
        input logic [`REG_ADDR_W-1:0] src
    );
        if (!(m_id.valid && read_en)) begin
            return pipe_pkg::FWD_NONE;
        end
        if (m_exe.valid && m_exe.writes_reg && (m_exe.dest == src)) begin
            return pipe_pkg::FWD_EXE;
        end
        if (m_mem1.valid && m_mem1.writes_reg && (m_mem1.dest == src)) begin
            return pipe_pkg::FWD_MEM1;
        end
        if (m_mem2.valid && m_mem2.writes_reg && (m_mem2.dest == src)) begin
            return pipe_pkg::FWD_MEM2;
        end
        return pipe_pkg::FWD_NONE;
    endfunction

    // Registers 0 to 3 only so hazards are frequent
    function automatic pipe_pkg::dec_instr_t random_instr();
        pipe_pkg::dec_instr_t d;
        logic [31:0]          r;
        r = $random(seed);
        // About one gap in five
        d.valid     = (r[7:0] % 8'd5) != 8'd0;
        d.rs        = {3'b000, r[9:8]};
        d.rt        = {3'b000, r[11:10]};
        d.dest      = {3'b000, r[13:12]};
        d.rsrt_read = r[15:14];
        d.is_load   = r[16];
        d.instr     = $random(seed);
        // Some non-loads become MFC0
        if (!d.is_load && (r[19:18] == 2'b00)) begin
            d.instr[`INSTR_W-1:`MFC0_LSB] = `MFC0_FIELD;
        end
        return d;
    endfunction

    // Quiet slice before anything is offered
    task automatic check_idle();
        @(negedge clk);
        assert (!issue && !dec_hold && (stall_flags == 3'b000) && !wb_out.valid) else begin
            err_idle++;
            $display("Error reset_idle: expected %b actual %b", 4'b0000,
                {issue, dec_hold, |stall_flags, wb_out.valid});
        end
    endtask

    // Per cycle check outputs, drive the decoder and step the model
    task automatic run_cycle(input bit drain);
        logic [2:0]             exp_stall;
        logic                   exp_issue;
        logic                   exp_hold;
        pipe_pkg::fwd_pair_t    exp_fwd;
        pipe_pkg::stage_entry_t issued;
        @(negedge clk);
        exp_stall      = model_stalls();
        exp_issue      = m_id.valid && (exp_stall == 3'b000);
        exp_hold       = m_id.valid && !exp_issue;
        exp_fwd.rs_sel = model_source(m_id.rsrt_read[1], m_id.rs);
        exp_fwd.rt_sel = model_source(m_id.rsrt_read[0], m_id.rt);

        assert (stall_flags === exp_stall) else begin
            err_stall++;
            $display("Error stall_flags: expected %b actual %b", exp_stall, stall_flags);
        end
        assert (issue === exp_issue) else begin
            err_issue++;
            $display("Error issue: expected %b actual %b", exp_issue, issue);
        end
        assert (dec_hold === exp_hold) else begin
            err_hold++;
            $display("Error dec_hold: expected %b actual %b", exp_hold, dec_hold);
        end
        // Selects only mean something on issue
        if (exp_issue) begin
            assert (issue_fwd === exp_fwd) else begin
                err_fwd++;
                $display("Error issue_fwd: expected %h actual %h", exp_fwd, issue_fwd);
            end
        end
        assert (wb_out === m_mem2) else begin
            err_wb++;
            $display("Error wb_out: expected %h actual %h", m_mem2, wb_out);
        end
        if (wb_out.valid === 1'b1) begin
            retired++;
        end

        // Decoder changes its word only while not held
        if (!exp_hold) begin
            if (drain) begin
                dec_in = '0;
            end else begin
                dec_in = random_instr();
            end
        end

        // Model view of the coming rising edge
        issued = '0;
        if (exp_issue) begin
            issued.valid      = 1'b1;
            issued.dest       = m_id.dest;
            issued.is_load    = m_id.is_load;
            issued.writes_reg = 1'b1;
            issued.instr      = m_id.instr;
        end
        m_mem2 = m_mem1;
        m_mem1 = m_exe;
        m_exe  = issued;
        if (!exp_hold) begin
            if (dec_in.valid) begin
                m_id = dec_in;
                offered++;
            end else begin
                m_id = '0;
            end
        end
    endtask

    initial begin
        seed        = 32'hb5e7;
        offered     = 0;
        retired     = 0;
        err_idle    = 0;
        err_stall   = 0;
        err_issue   = 0;
        err_hold    = 0;
        err_fwd     = 0;
        err_wb      = 0;
        err_count   = 0;
        err_timeout = 0;
        m_id        = '0;
        m_exe       = '0;
        m_mem1      = '0;
        m_mem2      = '0;
        reset       = 1'b1;
        dec_in      = '0;

        // Reset held for 8 cycles and released on a falling edge
        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < IDLE_CYCLES; i++) begin
            check_idle();
        end

        for (int i = 0; i < MAIN_CYCLES; i++) begin
            run_cycle(1'b0);
        end

        // Gaps only until every captured instruction has retired
        drained     = 1'b0;
        wait_cycles = 0;
        while (!drained && (wait_cycles < DRAIN_LIMIT)) begin
            run_cycle(1'b1);
            wait_cycles++;
            if (retired == offered) begin
                drained = 1'b1;
            end
        end
        if (!drained) begin
            err_timeout++;
            $display("Timeout: pipeline did not drain within %0d cycles", DRAIN_LIMIT);
        end

        assert (retired == offered) else begin
            err_count++;
            $display("Error retire_count: expected %0d actual %0d", offered, retired);
        end

        total_errors = err_idle + err_stall + err_issue + err_hold + err_fwd + err_wb
            + err_count + err_timeout;
        $write("Summary offered=%0d retired=%0d idle=%0d stall=%0d issue=%0d ",
            offered, retired, err_idle, err_stall, err_issue);
        $display("hold=%0d fwd=%0d wb=%0d count=%0d timeout=%0d",
            err_hold, err_fwd, err_wb, err_count, err_timeout);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
